// File: rtl/cpu_pkg.sv
package cpu_pkg;

	// data word, byte address and instruction all share one width
	typedef logic [15:0] word_t;

	// register index, also the 4-bit immediate of shifts and memory ops
	typedef logic [3:0] reg_idx_t;

	// stored condition flags
	typedef logic [2:0] flags_t;

	// bit positions inside flags_t
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// instruction field positions
	localparam int OPCODE_LSB = 12;
	localparam int RD_LSB = 8;
	localparam int RS_LSB = 4;
	localparam int RT_LSB = 0;
	// branch condition sits just under the opcode
	localparam int COND_LSB = 9;
	// signed word offset of B, starting at bit 0
	localparam int OFFSET_W = 9;
	// byte immediate of LLB and LHB, starting at bit 0
	localparam int IMM8_W = 8;

	// opcodes 7 and 13 are unused and behave as no-ops
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		XOR = 4'd2,
		AND = 4'd3,
		SLL = 4'd4,
		SRA = 4'd5,
		ROR = 4'd6,
		LW  = 4'd8,
		SW  = 4'd9,
		LLB = 4'd10,
		LHB = 4'd11,
		B   = 4'd12,
		PCS = 4'd14,
		HLT = 4'd15
	} opcode_t;

	// branch conditions, tested against the stored flags
	typedef enum logic [2:0] {
		NE = 3'd0,
		EQ = 3'd1,
		GT = 3'd2,
		LT = 3'd3,
		GE = 3'd4,
		LE = 3'd5,
		OV = 3'd6,
		UN = 3'd7
	} cond_t;

endpackage

// File: rtl/memory.sv
`timescale 1ns/10ps

module memory #(
	parameter int ADDR_W = 8
) (
	input logic clk,
	input cpu_pkg::word_t addr,
	input logic wen,
	input cpu_pkg::word_t wdata,
	output cpu_pkg::word_t rdata
);
	import cpu_pkg::*;

	// word storage, no reset on contents
	word_t mem [2**ADDR_W];

	// byte address, bit 0 dropped to get the word index
	logic [ADDR_W-1:0] word_idx;

	assign word_idx = addr[ADDR_W:1];

	// asynchronous read so fetch and load complete in the same cycle
	assign rdata = mem[word_idx];

	// write lands on the rising edge
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[word_idx] <= wdata;
		end
	end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/10ps

module register_file (
	input logic clk,
	input logic rst,
	input cpu_pkg::reg_idx_t src1,
	input cpu_pkg::reg_idx_t src2,
	input cpu_pkg::reg_idx_t dst,
	input logic wen,
	input cpu_pkg::word_t wdata,
	input cpu_pkg::reg_idx_t dbg_addr,
	output cpu_pkg::word_t data1,
	output cpu_pkg::word_t data2,
	output cpu_pkg::word_t dbg_data
);
	import cpu_pkg::*;

	// sixteen general registers, r0 is never written
	word_t regs [16];

	// combinational reads, r0 is forced to zero on every port
	assign data1 = (src1 == '0) ? '0 : regs[src1];
	assign data2 = (src2 == '0) ? '0 : regs[src2];
	assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && dst != '0) begin
			// writes to r0 are dropped here
			regs[dst] <= wdata;
		end
	end

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/10ps

module control_unit (
	input cpu_pkg::opcode_t opcode,
	output logic reg_write,
	output logic mem_write,
	output logic alu_imm,
	output logic mem_to_reg,
	output logic pcs,
	output logic llb,
	output logic lhb,
	output logic branch,
	output logic halt
);
	import cpu_pkg::*;

	always_comb begin
		// defaults cover the unused opcodes as no-ops
		reg_write = 1'b0;
		mem_write = 1'b0;
		alu_imm = 1'b0;
		mem_to_reg = 1'b0;
		pcs = 1'b0;
		llb = 1'b0;
		lhb = 1'b0;
		branch = 1'b0;
		halt = 1'b0;
		case (opcode)
			// register alu ops and shifts write rd
			ADD, SUB, XOR, AND, SLL, SRA, ROR: begin
				reg_write = 1'b1;
			end
			// address = rs + (imm << 1), result comes from dmem
			LW: begin
				reg_write = 1'b1;
				alu_imm = 1'b1;
				mem_to_reg = 1'b1;
			end
			// same address path, rd is the store data
			SW: begin
				mem_write = 1'b1;
				alu_imm = 1'b1;
			end
			// byte merge into the old rd value
			LLB: begin
				reg_write = 1'b1;
				llb = 1'b1;
			end
			LHB: begin
				reg_write = 1'b1;
				lhb = 1'b1;
			end
			B: begin
				branch = 1'b1;
			end
			// rd gets the address of the next instruction
			PCS: begin
				reg_write = 1'b1;
				pcs = 1'b1;
			end
			HLT: begin
				halt = 1'b1;
			end
			default: begin
				reg_write = 1'b0;
			end
		endcase
	end

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps

module alu (
	input cpu_pkg::opcode_t opcode,
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input cpu_pkg::reg_idx_t imm,
	input logic alu_imm,
	output cpu_pkg::word_t result,
	output cpu_pkg::flags_t flags_new,
	output cpu_pkg::flags_t flags_wen
);
	import cpu_pkg::*;

	// second operand, register or scaled offset for memory ops
	word_t b_op;
	word_t sum;
	word_t diff;
	// doubled word so a right shift gives the rotate
	logic [31:0] rot;
	logic ovf;

	// offset counts words, so shift it into a byte offset
	assign b_op = alu_imm ? {{11{imm[3]}}, imm, 1'b0} : b;

	// both wrap on overflow
	assign sum = a + b_op;
	assign diff = a - b_op;
	assign rot = {a, a} >> imm;

	always_comb begin
		ovf = 1'b0;
		case (opcode)
			ADD: begin
				result = sum;
				// same-sign operands giving a result of the other sign
				ovf = (a[15] == b_op[15]) && (sum[15] != a[15]);
			end
			SUB: begin
				result = diff;
				ovf = (a[15] != b_op[15]) && (diff[15] != a[15]);
			end
			XOR: result = a ^ b_op;
			AND: result = a & b_op;
			SLL: result = a << imm;
			// arithmetic shift keeps the sign bit
			SRA: result = word_t'($signed(a) >>> imm);
			ROR: result = rot[15:0];
			// LW and SW land here with the address sum
			default: result = sum;
		endcase
	end

	always_comb begin
		flags_new = '0;
		flags_new[FLAG_Z] = (result == '0);
		flags_new[FLAG_V] = ovf;
		flags_new[FLAG_N] = result[15];
	end

	// write mask per opcode
	always_comb begin
		flags_wen = '0;
		case (opcode)
			// arithmetic updates all three
			ADD, SUB: flags_wen = '1;
			// logic and shifts touch only Z
			XOR, AND, SLL, SRA, ROR: flags_wen[FLAG_Z] = 1'b1;
			default: flags_wen = '0;
		endcase
	end

endmodule

// File: rtl/pc_control.sv
`timescale 1ns/10ps

module pc_control (
	input logic clk,
	input logic rst,
	input cpu_pkg::word_t instr,
	input logic branch,
	input logic halt,
	input cpu_pkg::flags_t flags_new,
	input cpu_pkg::flags_t flags_wen,
	output cpu_pkg::word_t pc,
	output logic hlt
);
	import cpu_pkg::*;

	// stored flags, read by the branch before this edge's update
	flags_t flags;
	cond_t cond;
	logic [OFFSET_W-1:0] offset;
	logic cond_met;
	word_t pc_plus2;
	word_t pc_target;
	word_t pc_next;

	assign cond = cond_t'(instr[COND_LSB +: 3]);
	assign offset = instr[OFFSET_W-1:0];

	always_comb begin
		case (cond)
			NE: cond_met = !flags[FLAG_Z];
			EQ: cond_met = flags[FLAG_Z];
			GT: cond_met = !flags[FLAG_Z] && !flags[FLAG_N];
			LT: cond_met = flags[FLAG_N];
			GE: cond_met = flags[FLAG_Z] || !flags[FLAG_N];
			LE: cond_met = flags[FLAG_N] || flags[FLAG_Z];
			OV: cond_met = flags[FLAG_V];
			default: cond_met = 1'b1;
		endcase
	end

	assign pc_plus2 = pc + 16'd2;
	// offset is in words, relative to the following instruction
	assign pc_target = pc_plus2 + {{(15 - OFFSET_W){offset[OFFSET_W-1]}}, offset, 1'b0};
	assign pc_next = (branch && cond_met) ? pc_target : pc_plus2;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			flags <= '0;
			hlt <= 1'b0;
		end else if (!hlt) begin
			// HLT keeps pc on its own address
			if (!halt) begin
				pc <= pc_next;
			end
			hlt <= halt;
			// only the masked bits change
			flags <= (flags & ~flags_wen) | (flags_new & flags_wen);
		end
	end

endmodule

// File: rtl/cpu.sv
`timescale 1ns/10ps

module cpu #(
	parameter int IMEM_ADDR_W = 8,
	parameter int DMEM_ADDR_W = 8
) (
	input logic clk,
	input logic rst,
	input logic load_en,
	input cpu_pkg::word_t load_addr,
	input cpu_pkg::word_t load_data,
	input cpu_pkg::reg_idx_t dbg_addr,
	output cpu_pkg::word_t dbg_data,
	output cpu_pkg::word_t pc,
	output logic hlt
);
	import cpu_pkg::*;

	// fetch side
	word_t instr;
	word_t imem_addr;
	logic imem_wen;
	opcode_t opcode;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	logic [IMM8_W-1:0] imm8;

	// raw decoder outputs
	logic reg_write_dec;
	logic mem_write_dec;
	logic branch_dec;
	logic halt_dec;
	logic alu_imm;
	logic mem_to_reg;
	logic pcs;
	logic llb;
	logic lhb;

	// state-changing controls after the halt check
	logic reg_write;
	logic mem_write;
	logic branch;
	logic halt;

	// datapath
	reg_idx_t src1;
	reg_idx_t src2;
	word_t data1;
	word_t data2;
	word_t alu_result;
	flags_t flags_new;
	flags_t flags_wen;
	word_t dmem_rdata;
	word_t pc_plus2;
	word_t wdata;

	// load port owns imem while reset is high
	assign imem_addr = rst ? load_addr : pc;
	assign imem_wen = rst && load_en;

	memory #(.ADDR_W(IMEM_ADDR_W)) imem (
		.clk(clk),
		.addr(imem_addr),
		.wen(imem_wen),
		.wdata(load_data),
		.rdata(instr)
	);

	assign opcode = opcode_t'(instr[OPCODE_LSB +: 4]);
	assign rd = instr[RD_LSB +: 4];
	assign rs = instr[RS_LSB +: 4];
	assign rt = instr[RT_LSB +: 4];
	assign imm8 = instr[IMM8_W-1:0];

	control_unit u_control (
		.opcode(opcode),
		.reg_write(reg_write_dec),
		.mem_write(mem_write_dec),
		.alu_imm(alu_imm),
		.mem_to_reg(mem_to_reg),
		.pcs(pcs),
		.llb(llb),
		.lhb(lhb),
		.branch(branch_dec),
		.halt(halt_dec)
	);

	// once halted, nothing may write state any more
	assign reg_write = reg_write_dec && !hlt;
	assign mem_write = mem_write_dec && !hlt;
	assign branch = branch_dec && !hlt;
	assign halt = halt_dec && !hlt;

	// LLB and LHB read rd to keep the other byte
	assign src1 = (llb || lhb) ? rd : rs;
	// SW stores rd, its low field is the offset
	assign src2 = mem_write_dec ? rd : rt;

	register_file u_regs (
		.clk(clk),
		.rst(rst),
		.src1(src1),
		.src2(src2),
		.dst(rd),
		.wen(reg_write),
		.wdata(wdata),
		.dbg_addr(dbg_addr),
		.data1(data1),
		.data2(data2),
		.dbg_data(dbg_data)
	);

	alu u_alu (
		.opcode(opcode),
		.a(data1),
		.b(data2),
		.imm(rt),
		.alu_imm(alu_imm),
		.result(alu_result),
		.flags_new(flags_new),
		.flags_wen(flags_wen)
	);

	// alu sum is the byte address for LW and SW
	memory #(.ADDR_W(DMEM_ADDR_W)) dmem (
		.clk(clk),
		.addr(alu_result),
		.wen(mem_write),
		.wdata(data2),
		.rdata(dmem_rdata)
	);

	pc_control u_pc (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.branch(branch),
		.halt(halt),
		.flags_new(flags_new),
		.flags_wen(flags_wen),
		.pc(pc),
		.hlt(hlt)
	);

	assign pc_plus2 = pc + 16'd2;

	// write-back select, first match wins
	always_comb begin
		if (pcs) begin
			wdata = pc_plus2;
		end else if (mem_to_reg) begin
			wdata = dmem_rdata;
		end else if (llb) begin
			wdata = {data1[15:8], imm8};
		end else if (lhb) begin
			wdata = {imm8, data1[7:0]};
		end else begin
			wdata = alu_result;
		end
	end

endmodule

// File: testbench/cpu_assert.sv
`timescale 1ns/10ps

module cpu_assert (
	input logic clk,
	input logic rst,
	input cpu_pkg::word_t pc,
	input logic hlt
);

	// number of assertion failures so far
	int fail_count = 0;

	// a reset edge always clears the halt latch
	hlt_low_in_reset: assert property (@(posedge clk) rst |=> !hlt)
		else begin
			fail_count++;
			$error("hlt still high after a reset edge");
		end

	// halted core keeps hlt up and pc frozen until the next reset
	halt_holds: assert property (@(posedge clk) disable iff (rst) hlt |=> hlt && $stable(pc))
		else begin
			fail_count++;
			$error("hlt dropped or pc moved while halted");
		end

	// instructions are word aligned
	pc_even: assert property (@(posedge clk) disable iff (rst) !pc[0])
		else begin
			fail_count++;
			$error("pc is odd");
		end

endmodule

bind cpu cpu_assert u_assert (
	.clk(clk),
	.rst(rst),
	.pc(pc),
	.hlt(hlt)
);

// File: testbench/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int MAX_WORDS = 256;
	localparam int NUM_PROGRAMS = 5;
	// each word is loaded once and run at most once, plus reset and two register dumps
	localparam int WATCHDOG_NS = NUM_PROGRAMS * (2 * MAX_WORDS + RESET_CYCLES + 40) * 20 + 1000;

	// architectural state seen by the reference model
	typedef struct packed {
		word_t pc;
		flags_t flags;
		logic hlt;
		logic [15:0][15:0] regs;
		logic [MAX_WORDS-1:0][15:0] dmem;
	} model_t;

	logic clk;
	logic rst;
	logic load_en;
	word_t load_addr;
	word_t load_data;
	reg_idx_t dbg_addr;
	word_t dbg_data;
	word_t pc;
	logic hlt;

	// program image, same words as the DUT instruction memory
	word_t prog [MAX_WORDS];
	int prog_len;
	model_t model;
	int errors;

	cpu DUT (
		.clk(clk),
		.rst(rst),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data),
		.pc(pc),
		.hlt(hlt)
	);

	always #10 clk = ~clk;

	// opcode, rd, rs, rt or 4-bit immediate
	function automatic word_t reg_format(logic [3:0] op, logic [3:0] rd, logic [3:0] rs,
			logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic word_t byte_format(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	// offset counts words from the next instruction
	function automatic word_t branch_format(logic [2:0] cond, logic [8:0] offset);
		return {B, cond, offset};
	endfunction

	task automatic append_word(input word_t w);
		prog[8'(prog_len)] = w;
		prog_len++;
	endtask

	// full 16-bit constant via LLB then LHB
	task automatic load_const(input logic [3:0] rd, input word_t value);
		append_word(byte_format(LLB, rd, value[7:0]));
		append_word(byte_format(LHB, rd, value[15:8]));
	endtask

	// one instruction of the ISA applied to a copy of the state
	function automatic model_t step_model(input word_t instr, input model_t s);
		model_t n;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		word_t a;
		word_t b;
		word_t res;
		word_t addr;
		word_t pc2;
		int wide;
		logic wr;
		logic taken;
		n = s;
		if (s.hlt) begin
			return n;
		end
		op = instr[15:12];
		rd = instr[11:8];
		rs = instr[7:4];
		rt = instr[3:0];
		a = s.regs[rs];
		b = s.regs[rt];
		pc2 = s.pc + 16'd2;
		// memory offset is a signed word count
		addr = a + word_t'(int'($signed(rt)) * 2);
		res = '0;
		wr = 1'b1;
		taken = 1'b0;
		n.pc = pc2;
		case (op)
			ADD, SUB: begin
				wide = (op == ADD) ? int'($signed(a)) + int'($signed(b))
					: int'($signed(a)) - int'($signed(b));
				res = word_t'(wide);
				// exact result outside the signed 16-bit range
				n.flags[FLAG_V] = (wide > 32767) || (wide < -32768);
				n.flags[FLAG_N] = res[15];
			end
			XOR: res = a ^ b;
			AND: res = a & b;
			SLL: res = a << rt;
			// vacated top bits take the sign
			SRA: res = (a >> rt) | (a[15] ? ~(16'hffff >> rt) : 16'h0000);
			ROR: res = (a >> rt) | (a << (5'd16 - {1'b0, rt}));
			LW: res = s.dmem[addr[8:1]];
			SW: begin
				n.dmem[addr[8:1]] = s.regs[rd];
				wr = 1'b0;
			end
			LLB: res = {s.regs[rd][15:8], instr[7:0]};
			LHB: res = {instr[7:0], s.regs[rd][7:0]};
			B: begin
				wr = 1'b0;
				case (instr[11:9])
					NE: taken = !s.flags[FLAG_Z];
					EQ: taken = s.flags[FLAG_Z];
					GT: taken = !s.flags[FLAG_Z] && !s.flags[FLAG_N];
					LT: taken = s.flags[FLAG_N];
					GE: taken = s.flags[FLAG_Z] || !s.flags[FLAG_N];
					LE: taken = s.flags[FLAG_N] || s.flags[FLAG_Z];
					OV: taken = s.flags[FLAG_V];
					default: taken = 1'b1;
				endcase
				if (taken) begin
					n.pc = pc2 + word_t'(int'($signed(instr[8:0])) * 2);
				end
			end
			PCS: res = pc2;
			HLT: begin
				n.hlt = 1'b1;
				n.pc = s.pc;
				wr = 1'b0;
			end
			// codes 7 and 13 do nothing
			default: wr = 1'b0;
		endcase
		if (op inside {ADD, SUB, XOR, AND, SLL, SRA, ROR}) begin
			n.flags[FLAG_Z] = (res == 16'h0000);
		end
		// r0 stays zero
		if (wr && rd != 4'd0) begin
			n.regs[rd] = res;
		end
		return n;
	endfunction

	task automatic check_word(input string sig, input word_t exp, input word_t act);
		assert (act === exp)
		else begin
			errors++;
			$display("FAIL %0t %s expected %h got %h", $time, sig, exp, act);
		end
	endtask

	task automatic check_pc_hlt();
		check_word("pc", model.pc, pc);
		check_word("hlt", 16'(model.hlt), 16'(hlt));
	endtask

	// one register per cycle through the debug port
	task automatic check_regs();
		reg_idx_t idx;
		for (int r = 0; r < 16; r++) begin
			idx = 4'(r);
			@(posedge clk);
			dbg_addr <= idx;
			@(negedge clk);
			check_word($sformatf("dbg_data[r%0d]", r), model.regs[idx], dbg_data);
		end
	endtask

	task automatic run_program();
		// program goes in through the load port while reset is high
		@(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < prog_len; i++) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= word_t'(2 * i);
			load_data <= prog[8'(i)];
		end
		@(posedge clk);
		load_en <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		// data memory keeps its contents across reset
		model.pc = '0;
		model.flags = '0;
		model.hlt = 1'b0;
		model.regs = '0;
		@(negedge clk);
		check_pc_hlt();
		check_regs();
		@(posedge clk);
		rst <= 1'b0;
		// lockstep, one committed instruction per edge
		@(negedge clk);
		while (!model.hlt) begin
			check_pc_hlt();
			model = step_model(prog[model.pc[8:1]], model);
			@(negedge clk);
		end
		check_pc_hlt();
		// sixteen more halted cycles pass during the dump
		check_regs();
		check_pc_hlt();
		prog_len = 0;
	endtask

	task automatic build_alu_program(input int n_ops);
		// r0 has to ignore this write
		append_word(byte_format(LLB, 4'd0, 8'($urandom)));
		for (int r = 1; r < 16; r++) begin
			load_const(4'(r), 16'($urandom));
		end
		// codes 0 to 6, register ops and shifts
		for (int i = 0; i < n_ops; i++) begin
			// random condition on the flags so far, taken skips the op below
			if (i > 0) begin
				append_word(branch_format(3'($urandom), 9'd1));
			end
			append_word(reg_format(4'($urandom_range(6, 0)), 4'($urandom), 4'($urandom),
				4'($urandom)));
		end
		append_word(reg_format(HLT, 0, 0, 0));
	endtask

	task automatic build_mem_program();
		// bases 0x0040 and 0x0080, r6 preset so a loaded zero is visible
		load_const(1, 16'h0040);
		load_const(11, 16'h0080);
		load_const(2, 16'h1234);
		load_const(3, 16'hbeef);
		load_const(6, 16'hffff);
		append_word(reg_format(SW, 2, 1, 4'd2));
		append_word(reg_format(SW, 3, 1, 4'hd));
		append_word(reg_format(SW, 0, 11, 4'd7));
		append_word(reg_format(SW, 3, 11, 4'h8));
		append_word(reg_format(LW, 4, 1, 4'd2));
		append_word(reg_format(LW, 5, 1, 4'hd));
		append_word(reg_format(LW, 6, 11, 4'd7));
		append_word(reg_format(LW, 7, 11, 4'h8));
		append_word(reg_format(LW, 0, 1, 4'd2));
		// overwrite the negative slot and read it straight back
		append_word(reg_format(SW, 2, 1, 4'hd));
		append_word(reg_format(LW, 8, 1, 4'hd));
		append_word(reg_format(PCS, 10, 0, 0));
		append_word(reg_format(HLT, 0, 0, 0));
	endtask

	task automatic build_branch_program();
		logic [3:0] op;
		logic [3:0] ra;
		logic [3:0] rb;
		int p;
		load_const(2, 16'h7fff);
		load_const(3, 16'h0001);
		load_const(4, 16'h8000);
		load_const(5, 16'hffff);
		load_const(6, 16'h0005);
		append_word(reg_format(PCS, 10, 0, 0));
		for (int c = 0; c < 8; c++) begin
			for (int s = 0; s < 3; s++) begin
				op = (s == 0) ? ADD : (s == 1) ? SUB : XOR;
				// pairs give overflow, zero sum, equal operands, negative results
				p = (c + s) % 4;
				ra = (p == 0) ? 4'd2 : (p == 1) ? 4'd5 : (p == 2) ? 4'd6 : 4'd4;
				rb = (p == 2) ? 4'd6 : 4'd3;
				append_word(reg_format(op, 1, ra, rb));
				// taken lands on the r9 marker, not taken writes r8 and hops over it
				append_word(branch_format(3'(c), 9'd2));
				append_word(byte_format(LLB, 8, 8'(3 * c + s + 1)));
				append_word(branch_format(UN, 9'd1));
				append_word(byte_format(LLB, 9, 8'(3 * c + s + 1)));
			end
		end
		append_word(reg_format(PCS, 12, 0, 0));
		append_word(reg_format(HLT, 0, 0, 0));
		// past the halt, never executed
		append_word(byte_format(LLB, 1, 8'haa));
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		dbg_addr = '0;
		errors = 0;
		prog_len = 0;
		model = '0;
		void'($urandom(75));
		repeat (3) begin
			build_alu_program(40);
			run_program();
		end
		build_mem_program();
		run_program();
		build_branch_program();
		run_program();
		$display("errors: checks %0d, assertions %0d", errors, DUT.u_assert.fail_count);
		if (errors == 0 && DUT.u_assert.fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: cpu.f
rtl/cpu_pkg.sv
rtl/memory.sv
rtl/register_file.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/pc_control.sv
rtl/cpu.sv
testbench/cpu_assert.sv
testbench/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the cpu testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb \
	-f cpu.f --Mdir obj_dir -o cpu_sim

status=0
./obj_dir/cpu_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation finished cleanly"
